// File: arm_decode_pkg.sv
package arm_decode_pkg;

    localparam int word_width    = 32;
    localparam int reg_idx_width = 4;

    typedef enum logic [4:0] {
        class_bx,
        class_block_xfer,
        class_branch,
        class_branch_link,
        class_swi,
        class_single_xfer,
        class_swap,
        class_mul,
        class_mul_long,
        class_half_reg,
        class_half_imm,
        class_msr,
        class_mrs,
        class_dp_imm,
        class_dp_reg_imm,
        class_dp_reg_reg,
        class_undef
    } instr_class_t;

    // Encodings follow the ARM condition field, bits 31:28
    typedef enum logic [3:0] {
        cond_eq, cond_ne, cond_cs, cond_cc,
        cond_mi, cond_pl, cond_vs, cond_vc,
        cond_hi, cond_ls, cond_ge, cond_lt,
        cond_gt, cond_le, cond_al, cond_nv
    } cond_t;

    typedef enum logic [1:0] {
        shift_lsl,
        shift_lsr,
        shift_asr,
        shift_ror
    } shift_type_t;

    // Rotated 8-bit immediate, used when bit 25 is set
    typedef struct packed {
        logic [3:0] rotate;
        logic [7:0] imm8;
    } op2_imm_form_t;

    // Register shifted by a 5-bit constant
    typedef struct packed {
        logic [4:0]  shift_amount;
        shift_type_t shift_type;
        logic        zero_bit;
        logic [3:0]  rm;
    } op2_shift_imm_form_t;

    // Register shifted by the low byte of rs
    typedef struct packed {
        logic [3:0]  rs;
        logic        zero_bit;
        shift_type_t shift_type;
        logic        one_bit;
        logic [3:0]  rm;
    } op2_shift_reg_form_t;

    typedef union packed {
        op2_imm_form_t       imm_form;
        op2_shift_imm_form_t shift_imm_form;
        op2_shift_reg_form_t shift_reg_form;
    } operand2_u;

endpackage

// File: arm_instr_decoder.sv
`timescale 1ns/1ps

module arm_instr_decoder (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     instr_valid,
    input  logic [arm_decode_pkg::word_width-1:0]    instr,
    output logic                                     dec_valid,
    output arm_decode_pkg::instr_class_t             instr_class,
    output arm_decode_pkg::cond_t                    cond,
    output logic [arm_decode_pkg::reg_idx_width-1:0] rn,
    output logic [arm_decode_pkg::reg_idx_width-1:0] rd,
    output logic [arm_decode_pkg::reg_idx_width-1:0] rs,
    output logic [arm_decode_pkg::reg_idx_width-1:0] rm,
    output logic [3:0]                               opcode,
    output logic                                     set_flags,
    output arm_decode_pkg::operand2_u                operand2
);

    import arm_decode_pkg::*;

    instr_class_t next_class;

    // Priority match, earlier patterns shadow later overlapping ones
    always_comb begin
        priority casez (instr)
            // Branch and exchange
            32'b????_0001_0010_1111_1111_1111_0001_????: next_class = class_bx;
            32'b????_100?_????_????_????_????_????_????: next_class = class_block_xfer;
            32'b????_1010_????_????_????_????_????_????: next_class = class_branch;
            32'b????_1011_????_????_????_????_????_????: next_class = class_branch_link;
            32'b????_1111_????_????_????_????_????_????: next_class = class_swi;

            // Register offset with bit 4 set is the undefined slot
            32'b????_01??_????_????_????_????_????_????: begin
                if (instr[25] && instr[4]) begin
                    next_class = class_undef;
                end else begin
                    next_class = class_single_xfer;
                end
            end

            32'b????_0001_0?00_????_????_0000_1001_????: next_class = class_swap;
            32'b????_0000_00??_????_????_????_1001_????: next_class = class_mul;
            32'b????_0000_1???_????_????_????_1001_????: next_class = class_mul_long;

            // Halfword and signed transfers
            32'b????_000?_?0??_????_????_0000_1??1_????: next_class = class_half_reg;
            32'b????_000?_?1??_????_????_????_1??1_????: next_class = class_half_imm;

            // Status register moves sit inside the DP space with S clear
            32'b????_00?1_0?10_????_1111_????_????_????: next_class = class_msr;
            32'b????_0001_0?00_1111_????_0000_0000_0000: next_class = class_mrs;

            32'b????_00??_????_????_????_????_????_????: begin
                if (instr[25]) begin
                    next_class = class_dp_imm;
                end else if (!instr[4]) begin
                    next_class = class_dp_reg_imm;
                end else begin
                    next_class = class_dp_reg_reg;
                end
            end

            // Coprocessor space and anything left over
            default: next_class = class_undef;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= instr_valid;
        end
    end

    // Fields hold between strobes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instr_class <= class_bx;
            cond        <= cond_eq;
            rn          <= '0;
            rd          <= '0;
            rs          <= '0;
            rm          <= '0;
            opcode      <= '0;
            set_flags   <= 1'b0;
            operand2    <= '0;
        end else if (instr_valid) begin
            instr_class <= next_class;
            cond        <= cond_t'(instr[31:28]);
            rn          <= instr[19:16];
            rd          <= instr[15:12];
            rs          <= instr[11:8];
            rm          <= instr[3:0];
            opcode      <= instr[24:21];
            set_flags   <= instr[20];
            operand2    <= operand2_u'(instr[11:0]);
        end
    end

    // One output cycle per strobe, carrying the word strobed on that edge
    a_valid_follows: assert property (
        @(posedge clk) disable iff (reset)
        instr_valid |=> dec_valid && (cond == cond_t'($past(instr[31:28])))
    );

    a_no_spurious_valid: assert property (
        @(posedge clk) disable iff (reset)
        !instr_valid |=> !dec_valid
    );

endmodule

// File: arm_cond_check.sv
`timescale 1ns/1ps

module arm_cond_check (
    input  arm_decode_pkg::cond_t cond,
    input  logic [3:0]            flags,
    output logic                  cond_pass
);

    import arm_decode_pkg::*;

    logic flag_n;
    logic flag_z;
    logic flag_c;
    logic flag_v;

    // NZCV order, N in the top bit
    assign flag_n = flags[3];
    assign flag_z = flags[2];
    assign flag_c = flags[1];
    assign flag_v = flags[0];

    always_comb begin
        unique case (cond)
            cond_eq: cond_pass = flag_z;
            cond_ne: cond_pass = !flag_z;
            cond_cs: cond_pass = flag_c;
            cond_cc: cond_pass = !flag_c;
            cond_mi: cond_pass = flag_n;
            cond_pl: cond_pass = !flag_n;
            cond_vs: cond_pass = flag_v;
            cond_vc: cond_pass = !flag_v;
            // Unsigned compares
            cond_hi: cond_pass = flag_c && !flag_z;
            cond_ls: cond_pass = !flag_c || flag_z;
            // Signed compares
            cond_ge: cond_pass = (flag_n == flag_v);
            cond_lt: cond_pass = (flag_n != flag_v);
            cond_gt: cond_pass = !flag_z && (flag_n == flag_v);
            cond_le: cond_pass = flag_z || (flag_n != flag_v);
            cond_al: cond_pass = 1'b1;
            // Never on ARMv4
            cond_nv: cond_pass = 1'b0;
            default: cond_pass = 1'b0;
        endcase
    end

endmodule

// File: arm_imm_expander.sv
`timescale 1ns/1ps

module arm_imm_expander (
    input  arm_decode_pkg::operand2_u                 operand2,
    output logic [arm_decode_pkg::word_width-1:0]     imm_value
);

    import arm_decode_pkg::*;

    logic [word_width-1:0]   imm_ext;
    logic [4:0]              rot_amount;
    logic [2*word_width-1:0] imm_doubled;

    assign imm_ext    = {{(word_width - 8){1'b0}}, operand2.imm_form.imm8};

    // Rotate field counts in steps of two bits
    assign rot_amount = {operand2.imm_form.rotate, 1'b0};

    // Shifting a doubled copy gives the rotate right
    assign imm_doubled = {imm_ext, imm_ext} >> rot_amount;
    assign imm_value   = imm_doubled[word_width-1:0];

    // Zero rotate must pass the byte through zero extended
    always_comb begin
        if (operand2.imm_form.rotate == 4'd0) begin
            a_zero_rotate: assert #0 (imm_value == imm_ext);
        end
    end

endmodule

// File: arm_decode_stage.sv
`timescale 1ns/1ps

module arm_decode_stage (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     instr_valid,
    input  logic [arm_decode_pkg::word_width-1:0]    instr,
    input  logic [3:0]                               flags,
    output logic                                     dec_valid,
    output arm_decode_pkg::instr_class_t             instr_class,
    output arm_decode_pkg::cond_t                    cond,
    output logic [arm_decode_pkg::reg_idx_width-1:0] rn,
    output logic [arm_decode_pkg::reg_idx_width-1:0] rd,
    output logic [arm_decode_pkg::reg_idx_width-1:0] rs,
    output logic [arm_decode_pkg::reg_idx_width-1:0] rm,
    output logic [3:0]                               opcode,
    output logic                                     set_flags,
    output arm_decode_pkg::operand2_u                operand2,
    output logic                                     cond_pass,
    output logic [arm_decode_pkg::word_width-1:0]    imm_value
);

    // Registered decode, one cycle after the strobe
    arm_instr_decoder i_decoder (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dec_valid   (dec_valid),
        .instr_class (instr_class),
        .cond        (cond),
        .rn          (rn),
        .rd          (rd),
        .rs          (rs),
        .rm          (rm),
        .opcode      (opcode),
        .set_flags   (set_flags),
        .operand2    (operand2)
    );

    // Live flags against the held condition
    arm_cond_check i_cond_check (
        .cond      (cond),
        .flags     (flags),
        .cond_pass (cond_pass)
    );

    arm_imm_expander i_imm_expander (
        .operand2  (operand2),
        .imm_value (imm_value)
    );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam int half_period  = 20;
    localparam int reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Reset released on a rising edge after the hold time
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: tb_arm_decode.sv
`timescale 1ns/1ps

module tb_arm_decode;

    import arm_decode_pkg::*;

    localparam int reset_cycles   = 10;
    localparam int class_words    = 20;
    localparam int imm_per_rotate = 4;
    localparam int random_words   = 300;
    localparam int max_gap        = 3;
    // Worst case cycles issued by all tests, plus margin
    localparam int timeout_cycles = reset_cycles + 5 * 8 + class_words + 2 * 256
        + 16 * imm_per_rotate + random_words * (max_gap + 1) + 100;

    // Directed words, all AL, including swap and mul words that also fit DP and halfword
    localparam logic [32*class_words-1:0] class_list = {
        32'hE12FFF13, 32'hE8BD800F, 32'hEA000010, 32'hEB000020, 32'hEF000011,
        32'hE5912004, 32'hE7912013, 32'hE1012093, 32'hE0010392, 32'hE0010092,
        32'hE0843291, 32'hE19120B3, 32'hE1D120B4, 32'hE129F003, 32'hE328F00F,
        32'hE10F0000, 32'hE3A01005, 32'hE0912A43, 32'hE0812313, 32'hEE000010
    };

    typedef struct packed {
        instr_class_t cls;
        cond_t        cond;
        logic [3:0]   rn, rd, rs, rm, opcode;
        logic         set_flags;
        operand2_u    op2;
        logic         cond_pass;
        logic [31:0]  imm_value;
    } expect_t;

    logic                     clk;
    logic                     reset;
    logic                     instr_valid;
    logic [word_width-1:0]    instr;
    logic [3:0]               flags;
    logic                     dec_valid;
    instr_class_t             instr_class;
    cond_t                    cond;
    logic [reg_idx_width-1:0] rn, rd, rs, rm;
    logic [3:0]               opcode;
    logic                     set_flags;
    operand2_u                operand2;
    logic                     cond_pass;
    logic [word_width-1:0]    imm_value;

    logic [31:0] exp_words[$];
    logic [31:0] cmp_word;
    expect_t     cmp_exp;
    expect_t     idle_exp;
    logic        strobe_seen;
    logic [31:0] rnd;
    logic [31:0] rnd_flags;
    int          cycle_count;
    int          check_count;
    int          error_count;
    int          test_count;
    int          test_checks;
    int          test_errors;
    int          seed;
    int          gap;
    int          i;
    int          j;

    tb_clock_gen i_clock_gen (.clk(clk), .reset(reset));

    arm_decode_stage i_dut (.*);

    // Expected outputs of one word from the ARM encoding rules
    function automatic expect_t ref_decode(input logic [31:0] w, input logic [3:0] fl);
        expect_t     e;
        logic        n, z, c, v, base;
        logic [31:0] rot;
        int          k;
        e = '0;
        n = fl[3];
        z = fl[2];
        c = fl[1];
        v = fl[0];
        if (w[27:4] == 24'h12FFF1) e.cls = class_bx;
        else if (w[27:25] == 3'b100) e.cls = class_block_xfer;
        else if (w[27:24] == 4'b1010) e.cls = class_branch;
        else if (w[27:24] == 4'b1011) e.cls = class_branch_link;
        else if (w[27:24] == 4'b1111) e.cls = class_swi;
        else if (w[27:26] == 2'b01) e.cls = (w[25] && w[4]) ? class_undef : class_single_xfer;
        else if (w[27:23] == 5'b00010 && w[21:20] == 2'b00 && w[11:4] == 8'h09)
            e.cls = class_swap;
        else if (w[27:22] == 6'b000000 && w[7:4] == 4'b1001) e.cls = class_mul;
        else if (w[27:23] == 5'b00001 && w[7:4] == 4'b1001) e.cls = class_mul_long;
        else if (w[27:25] == 3'b000 && !w[22] && w[11:8] == 4'h0 && w[7] && w[4])
            e.cls = class_half_reg;
        else if (w[27:25] == 3'b000 && w[22] && w[7] && w[4]) e.cls = class_half_imm;
        else if (w[27:26] == 2'b00 && w[24:23] == 2'b10 && w[21:20] == 2'b10 && w[15:12] == 4'hF)
            e.cls = class_msr;
        else if (w[27:23] == 5'b00010 && w[21:16] == 6'b001111 && w[11:0] == 12'h000)
            e.cls = class_mrs;
        else if (w[27:26] == 2'b00)
            e.cls = w[25] ? class_dp_imm : (w[4] ? class_dp_reg_reg : class_dp_reg_imm);
        else e.cls = class_undef;
        e.cond                = cond_t'(w[31:28]);
        e.rn                  = w[19:16];
        e.rd                  = w[15:12];
        e.rs                  = w[11:8];
        e.rm                  = w[3:0];
        e.opcode              = w[24:21];
        e.set_flags           = w[20];
        e.op2.imm_form.rotate = w[11:8];
        e.op2.imm_form.imm8   = w[7:0];
        // Odd codes invert their even partner, NV never passes
        case (w[31:29])
            3'd0: base = z;
            3'd1: base = c;
            3'd2: base = n;
            3'd3: base = v;
            3'd4: base = c && !z;
            3'd5: base = (n == v);
            3'd6: base = !z && (n == v);
            default: base = 1'b1;
        endcase
        e.cond_pass = (w[31:28] == 4'hF) ? 1'b0 : (base ^ w[28]);
        // Rotate right one bit at a time
        rot = {24'h0, w[7:0]};
        for (k = 0; k < 2 * w[11:8]; k++)
            rot = {rot[0], rot[31:1]};
        e.imm_value = rot;
        return e;
    endfunction

    task automatic check_class(input logic [31:0] w, input instr_class_t got, exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR at %0t: %h class %s, expected %s", $time, w, got.name(), exp.name());
        end
    endtask

    task automatic check_fields(input logic [31:0] w, input logic [20:0] got, exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR at %0t: %h rn rd rs rm op %h s %b, expected %h s %b",
                     $time, w, got[20:1], got[0], exp[20:1], exp[0]);
        end
    endtask

    task automatic check_cond(input logic [31:0] w, input cond_t got, exp,
                              input logic pass_got, pass_exp);
        check_count++;
        if (got !== exp || pass_got !== pass_exp) begin
            error_count++;
            $display("ERROR at %0t: %h flags %b cond %s pass %b, expected %s pass %b",
                     $time, w, flags, got.name(), pass_got, exp.name(), pass_exp);
        end
    endtask

    task automatic check_operand2(input logic [31:0] w, input operand2_u got, exp,
                                  input logic [31:0] imm_got, imm_exp);
        logic views_ok;
        // Shift views read straight from the bit positions of the word
        views_ok = (got.shift_imm_form.shift_amount === w[11:7])
            && (got.shift_imm_form.shift_type === shift_type_t'(w[6:5]))
            && (got.shift_imm_form.rm === w[3:0])
            && (got.shift_reg_form.rs === w[11:8])
            && (got.shift_reg_form.shift_type === shift_type_t'(w[6:5]))
            && (got.shift_reg_form.rm === w[3:0]);
        check_count++;
        if (got !== exp || imm_got !== imm_exp || !views_ok) begin
            error_count++;
            $display("ERROR at %0t: %h op2 %h (rot %0d shamt %0d rs %h) imm %h, exp %h imm %h",
                     $time, w, got, got.imm_form.rotate, got.shift_imm_form.shift_amount,
                     got.shift_reg_form.rs, imm_got, exp, imm_exp);
        end
    endtask

    task automatic compare_all(input logic [31:0] w, input expect_t e);
        check_class(w, instr_class, e.cls);
        check_fields(w, {rn, rd, rs, rm, opcode, set_flags},
                     {e.rn, e.rd, e.rs, e.rm, e.opcode, e.set_flags});
        check_cond(w, cond, e.cond, cond_pass, e.cond_pass);
        check_operand2(w, operand2, e.op2, imm_value, e.imm_value);
    endtask

    task automatic send_word(input logic [31:0] w, input logic [3:0] fl);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= w;
        flags       <= fl;
        exp_words.push_back(w);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            instr_valid <= 1'b0;
        end
    endtask

    task automatic end_test(input string name);
        idle(1);
        while (exp_words.size() != 0)
            @(negedge clk);
        @(posedge clk);
        test_count++;
        $display("Test %0d %s done: %0d checks, %0d errors", test_count, name,
                 check_count - test_checks, error_count - test_errors);
        test_checks = check_count;
        test_errors = error_count;
    endtask

    // Cycle counter with a hard stop, and the strobe seen on each edge
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        strobe_seen <= instr_valid;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout after %0d cycles, %0d words never produced dec_valid",
                     cycle_count, exp_words.size());
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Each dec_valid cycle retires the oldest strobed word
    always @(negedge clk) begin
        if (!reset) begin
            if (dec_valid !== strobe_seen) begin
                error_count++;
                $display("dec_valid was %b at %0t but instr_valid was %b on the edge before",
                         dec_valid, $time, strobe_seen);
            end
            if (dec_valid === 1'b1 && exp_words.size() != 0) begin
                cmp_word = exp_words.pop_front();
                cmp_exp  = ref_decode(cmp_word, flags);
                compare_all(cmp_word, cmp_exp);
            end
        end
    end

    initial begin
        seed        = 14265;
        instr_valid = 1'b0;
        instr       = '0;
        flags       = 4'b0100;
        @(negedge reset);
        // Cleared cond reads as EQ, so the pass bit follows Z
        repeat (4) begin
            @(negedge clk);
            idle_exp           = '0;
            idle_exp.cond_pass = flags[2];
            compare_all(32'h0, idle_exp);
        end
        end_test("reset");
        for (i = 0; i < class_words; i++) begin
            rnd_flags = $random(seed);
            send_word(class_list[32*i +: 32], rnd_flags[3:0]);
        end
        end_test("class");
        // Flags held through the output cycle of each word
        for (i = 0; i < 16; i++) begin
            for (j = 0; j < 16; j++) begin
                send_word({i[3:0], 28'h0812003}, j[3:0]);
                idle(1);
            end
        end
        end_test("cond");
        // MOV with every rotate value and random imm8 and rd
        for (i = 0; i < 16 * imm_per_rotate; i++) begin
            rnd = $random(seed);
            send_word({8'hE3, 4'hA, 4'h0, rnd[11:8], i[5:2], rnd[7:0]}, rnd[15:12]);
        end
        end_test("imm");
        for (i = 0; i < random_words; i++) begin
            rnd       = $random(seed);
            rnd_flags = $random(seed);
            gap       = $random(seed) & max_gap;
            send_word(rnd, rnd_flags[3:0]);
            idle(gap);
        end
        end_test("random");
        $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: flist.f
arm_decode_pkg.sv
arm_instr_decoder.sv
arm_cond_check.sv
arm_imm_expander.sv
arm_decode_stage.sv
tb_clock_gen.sv
tb_arm_decode.sv
